//--- compile.f
+incdir+verification
hw/soc_bus_pkg.sv
hw/wb_if.sv
hw/wb_master_arbiter.sv
hw/wb_addr_decoder.sv
hw/wb_bus_router.sv
hw/soc_sram.sv
hw/soc_bus_top.sv
verification/tb_soc_bus.sv

//--- verification/tb_soc_bus_tasks.svh
// Value check, bus master tasks and directed tests
// Included inside the testbench top module

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
   if (actual !== expected)
   begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   end
endtask

task automatic drive_req(input int mst, input logic [31:0] adr, input logic we,
                         input logic [31:0] dat, input logic [3:0] sel);
   m_adr[mst]  = adr;
   m_wdat[mst] = dat;
   m_sel[mst]  = sel;
   m_we[mst]   = we;
   m_cyc[mst]  = 1'b1;
   m_stb[mst]  = 1'b1;
endtask

task automatic release_req(input int mst);
   m_cyc[mst] = 1'b0;
   m_stb[mst] = 1'b0;
endtask

// Resp is {err, ack}
// Cycles counts the rising edges waited
task automatic wait_resp(input int mst, output logic [1:0] resp, output logic [31:0] rdat,
                         output int cycles);
   resp   = 2'b00;
   rdat   = '0;
   cycles = 0;
   while (resp == 2'b00)
   begin
      if (cycles == TIMEOUT)
      begin
         $display("Timeout at %0t ns: %s access to %h got neither ack nor err",
                  $time, (mst == DMA) ? "DMA" : "CPU", m_adr[mst]);
         $display("*** FAILED ***");
         $fatal(1, "Simulation stopped on a hung access");
      end
      @(posedge clk);
      cycles++;
      resp = {m_err[mst], m_ack[mst]};
      rdat = m_rdat[mst];
   end
endtask

task automatic bus_access(input int mst, input logic [31:0] adr, input logic we,
                          input logic [31:0] dat, input logic [3:0] sel,
                          output logic [1:0] resp, output logic [31:0] rdat,
                          output int cycles);
   @(negedge clk);
   drive_req(mst, adr, we, dat, sel);
   wait_resp(mst, resp, rdat, cycles);
   @(negedge clk);
   release_req(mst);
endtask

task automatic test_reset();
   check_equal({m_ack, m_err}, 4'b0000, "Master ack or err after reset");
   check_equal({s_cyc, s_stb}, 4'b0000, "Slave cyc or stb after reset");
endtask

task automatic test_sram();
   logic [31:0] data [8];
   logic [31:0] rdat;
   logic [1:0]  resp;
   int          cycles;
   int          mst;
   for (int i = 0; i < 8; i++)
   begin
      data[i] = $random(seed);
      mst     = (i < 4) ? CPU : DMA;
      bus_access(mst, i * 4, 1'b1, data[i], 4'hf, resp, rdat, cycles);
      check_equal(resp, 2'b01, "SRAM write response");
      // Ack is registered on the second edge and sampled on the third
      check_equal(cycles, 3, "SRAM write latency on an idle bus");
   end
   for (int i = 0; i < 8; i++)
   begin
      mst = (i < 4) ? DMA : CPU;
      bus_access(mst, i * 4, 1'b0, '0, 4'hf, resp, rdat, cycles);
      check_equal(resp, 2'b01, "SRAM read response");
      check_equal(rdat, data[i], "SRAM read back through the other port");
   end
   bus_access(CPU, 32'h40, 1'b1, data[0], 4'hf, resp, rdat, cycles);
   bus_access(CPU, 32'h40, 1'b1, data[1], 4'b0101, resp, rdat, cycles);
   bus_access(DMA, 32'h40, 1'b0, '0, 4'hf, resp, rdat, cycles);
   check_equal(rdat, {data[0][31:24], data[1][23:16], data[0][15:8], data[1][7:0]},
               "SRAM word after a write with sel 0101");
endtask

task automatic test_routing();
   logic [31:0] wdat;
   logic [31:0] rdat;
   logic [1:0]  resp;
   int          cycles;
   int          hits_before;
   wdat          = $random(seed);
   s_data[ETH]   = $random(seed);
   s_data[UART]  = $random(seed);
   s_delay[ETH]  = 0;
   s_delay[UART] = 0;
   hits_before   = hits[UART];
   bus_access(CPU, 32'h9200_1234, 1'b1, wdat, 4'b0110, resp, rdat, cycles);
   check_equal(resp, 2'b01, "Ethernet write response");
   check_equal(seen_adr[ETH], 32'h9200_1234, "Address on the Ethernet port");
   check_equal(seen_dat[ETH], wdat, "Write data on the Ethernet port");
   check_equal(seen_sel[ETH], 4'b0110, "Sel on the Ethernet port");
   check_equal(seen_we[ETH], 1'b1, "We on the Ethernet port");
   bus_access(CPU, 32'h9200_0010, 1'b0, '0, 4'hf, resp, rdat, cycles);
   check_equal(rdat, s_data[ETH], "Ethernet read data on cpu_dat_o");
   check_equal(hits[UART], hits_before, "UART accesses during Ethernet traffic");
   hits_before = hits[ETH];
   bus_access(CPU, 32'h90AB_CDEC, 1'b1, wdat, 4'b1100, resp, rdat, cycles);
   check_equal(resp, 2'b01, "UART write response");
   check_equal(seen_adr[UART], 32'h00AB_CDEC, "Low 24 address bits on the UART port");
   check_equal(seen_dat[UART], wdat, "Write data on the UART port");
   check_equal(seen_sel[UART], 4'b1100, "Sel on the UART port");
   check_equal(seen_we[UART], 1'b1, "We on the UART port");
   bus_access(CPU, 32'h9000_0004, 1'b0, '0, 4'hf, resp, rdat, cycles);
   check_equal(rdat, s_data[UART], "UART read data on cpu_dat_o");
   check_equal(seen_we[UART], 1'b0, "We on the UART port for a read");
   check_equal(hits[ETH], hits_before, "Ethernet accesses during UART traffic");
endtask

task automatic test_errors();
   logic [31:0] wdat;
   logic [31:0] rdat;
   logic [1:0]  resp;
   int          cycles;
   wdat = $random(seed);
   bus_access(CPU, 32'h5000_0000, 1'b0, '0, 4'hf, resp, rdat, cycles);
   check_equal(resp, 2'b10, "Response to unmapped prefix 0x50");
   check_equal(cycles, 2, "Error latency on an idle bus");
   bus_access(DMA, 32'h0000_0000, 1'b1, wdat, 4'hf, resp, rdat, cycles);
   bus_access(DMA, 32'h0000_0400, 1'b1, ~wdat, 4'hf, resp, rdat, cycles);
   check_equal(resp, 2'b10, "Response to SRAM word 256");
   // Word 256 must not wrap onto word 0
   bus_access(CPU, 32'h0000_0000, 1'b0, '0, 4'hf, resp, rdat, cycles);
   check_equal(rdat, wdat, "SRAM word 0 after the word 256 write");
endtask

task automatic test_priority();
   logic [31:0] wdat [3];
   logic [31:0] rdat;
   logic [1:0]  resp;
   int          cycles;
   int          cpu_before;
   for (int i = 0; i < 3; i++)
      wdat[i] = $random(seed);
   cpu_before = acks[CPU];
   @(negedge clk);
   drive_req(DMA, 32'h80, 1'b1, wdat[0], 4'hf);
   drive_req(CPU, 32'h88, 1'b1, wdat[2], 4'hf);
   wait_resp(DMA, resp, rdat, cycles);
   check_equal(resp, 2'b01, "DMA response to the first transfer");
   // Second DMA transfer keeps cyc high
   @(negedge clk);
   drive_req(DMA, 32'h84, 1'b1, wdat[1], 4'hf);
   wait_resp(DMA, resp, rdat, cycles);
   check_equal(resp, 2'b01, "DMA response to the second transfer");
   @(negedge clk);
   check_equal(acks[CPU], cpu_before, "CPU acks while DMA holds the bus");
   release_req(DMA);
   wait_resp(CPU, resp, rdat, cycles);
   check_equal(resp, 2'b01, "CPU response after DMA released the bus");
   @(negedge clk);
   release_req(CPU);
   bus_access(DMA, 32'h84, 1'b0, '0, 4'hf, resp, rdat, cycles);
   check_equal(rdat, wdat[1], "Second DMA write data");
   bus_access(DMA, 32'h88, 1'b0, '0, 4'hf, resp, rdat, cycles);
   check_equal(rdat, wdat[2], "Delayed CPU write data");
endtask

task automatic test_backpressure();
   logic [31:0] rdat;
   logic [1:0]  resp;
   int          cycles;
   int          acks_before;
   int          hits_before;
   acks_before = acks[CPU];
   hits_before = hits[ETH];
   for (int i = 0; i < 4; i++)
   begin
      s_delay[ETH] = 1 + ($unsigned($random(seed)) % 5);
      s_data[ETH]  = $random(seed);
      bus_access(CPU, 32'h9200_0100 + i * 4, 1'b0, '0, 4'hf, resp, rdat, cycles);
      check_equal(resp, 2'b01, "CPU response to a stalled Ethernet read");
      check_equal(rdat, s_data[ETH], "Stalled Ethernet read data");
      // Grant edge, one edge per stall cycle, ack edge and the sampling edge
      check_equal(cycles, s_delay[ETH] + 3, "CPU request held through the stall");
   end
   check_equal(acks[CPU] - acks_before, 4, "CPU acks for four requests");
   check_equal(hits[ETH] - hits_before, 4, "Ethernet requests served");
endtask

//--- verification/tb_soc_bus.sv
// Testbench top for the Wishbone switch with clock, reset and DUT
// Ethernet and UART slave models, ack monitor and the test sequence
`timescale 1ns/1ns

module tb_soc_bus;

   localparam int TIMEOUT = 40;
   localparam int DMA     = 0;
   localparam int CPU     = 1;
   localparam int ETH     = 0;
   localparam int UART    = 1;

   logic             clk = 1'b0;
   logic             rst;
   int               seed;

   // Master ports indexed by DMA or CPU
   logic [1:0][31:0] m_adr;
   logic [1:0][31:0] m_wdat;
   logic [1:0][3:0]  m_sel;
   logic [1:0]       m_we;
   logic [1:0]       m_cyc;
   logic [1:0]       m_stb;
   wire  [1:0][31:0] m_rdat;
   wire  [1:0]       m_ack;
   wire  [1:0]       m_err;
   int               acks [2];

   // Slave ports indexed by ETH or UART
   wire  [1:0][31:0] s_adr;
   wire  [23:0]      uart_adr;
   wire  [1:0][31:0] s_wdat;
   wire  [1:0][3:0]  s_sel;
   wire  [1:0]       s_we;
   wire  [1:0]       s_cyc;
   wire  [1:0]       s_stb;
   logic [1:0][31:0] s_rdat;
   logic [1:0]       s_ack;
   logic [1:0]       s_err;

   // Model settings and what each model saw
   int               s_delay [2];
   logic [31:0]      s_data [2];
   int               wait_cnt [2];
   logic [1:0]       ack_due = '0;
   int               hits [2];
   logic [31:0]      seen_adr [2];
   logic [31:0]      seen_dat [2];
   logic [3:0]       seen_sel [2];
   logic             seen_we [2];

   assign s_adr[UART] = {8'h00, uart_adr};

   soc_bus_top #(
      .SRAM_ADR_WIDTH (8)
   ) dut_i (
      .wb_clk_i   (clk),
      .rst_i      (rst),
      .dma_adr_i  (m_adr[DMA]),
      .dma_dat_i  (m_wdat[DMA]),
      .dma_sel_i  (m_sel[DMA]),
      .dma_we_i   (m_we[DMA]),
      .dma_cyc_i  (m_cyc[DMA]),
      .dma_stb_i  (m_stb[DMA]),
      .dma_dat_o  (m_rdat[DMA]),
      .dma_ack_o  (m_ack[DMA]),
      .dma_err_o  (m_err[DMA]),
      .cpu_adr_i  (m_adr[CPU]),
      .cpu_dat_i  (m_wdat[CPU]),
      .cpu_sel_i  (m_sel[CPU]),
      .cpu_we_i   (m_we[CPU]),
      .cpu_cyc_i  (m_cyc[CPU]),
      .cpu_stb_i  (m_stb[CPU]),
      .cpu_dat_o  (m_rdat[CPU]),
      .cpu_ack_o  (m_ack[CPU]),
      .cpu_err_o  (m_err[CPU]),
      .eth_adr_o  (s_adr[ETH]),
      .eth_dat_o  (s_wdat[ETH]),
      .eth_sel_o  (s_sel[ETH]),
      .eth_we_o   (s_we[ETH]),
      .eth_cyc_o  (s_cyc[ETH]),
      .eth_stb_o  (s_stb[ETH]),
      .eth_dat_i  (s_rdat[ETH]),
      .eth_ack_i  (s_ack[ETH]),
      .eth_err_i  (s_err[ETH]),
      .uart_adr_o (uart_adr),
      .uart_dat_o (s_wdat[UART]),
      .uart_sel_o (s_sel[UART]),
      .uart_we_o  (s_we[UART]),
      .uart_cyc_o (s_cyc[UART]),
      .uart_stb_o (s_stb[UART]),
      .uart_dat_i (s_rdat[UART]),
      .uart_ack_i (s_ack[UART]),
      .uart_err_i (s_err[UART])
   );

   `include "tb_soc_bus_tasks.svh"

   initial
   begin
      forever #4 clk = ~clk;
   end

   // Slave models ack after s_delay cycles of a held request
   always @(posedge clk)
   begin
      for (int i = 0; i < 2; i++)
      begin
         ack_due[i] = 1'b0;
         if (s_cyc[i] && s_stb[i] && !s_ack[i])
         begin
            if (wait_cnt[i] < s_delay[i])
            begin
               wait_cnt[i]++;
            end
            else
            begin
               wait_cnt[i] = 0;
               ack_due[i]  = 1'b1;
               hits[i]++;
               seen_adr[i] = s_adr[i];
               seen_dat[i] = s_wdat[i];
               seen_sel[i] = s_sel[i];
               seen_we[i]  = s_we[i];
            end
         end
      end
   end

   // Ack lasts one cycle, read data goes out with it
   always @(negedge clk)
   begin
      for (int i = 0; i < 2; i++)
      begin
         if (ack_due[i])
            s_rdat[i] = s_data[i];
         s_ack[i] = ack_due[i];
      end
   end

   // Every ack that a master sees
   always @(posedge clk)
   begin
      for (int i = 0; i < 2; i++)
      begin
         if (m_ack[i])
            acks[i]++;
      end
   end

   initial
   begin
      seed         = 3;
      rst          = 1'b1;
      m_adr        = '0;
      m_wdat       = '0;
      m_sel        = '0;
      m_we         = '0;
      m_cyc        = '0;
      m_stb        = '0;
      s_rdat       = '0;
      s_ack        = '0;
      s_err        = '0;
      s_data[ETH]  = '0;
      s_data[UART] = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      test_reset();
      test_sram();
      test_routing();
      test_errors();
      test_priority();
      test_backpressure();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- hw/soc_bus_top.sv
// Wishbone switch top level with two masters, SRAM, Ethernet and UART
// Plain bus ports mapped onto the internal interfaces
`timescale 1ns/1ns

module soc_bus_top #(
   parameter int SRAM_ADR_WIDTH = 8
) (
   input  logic                                    wb_clk_i,
   input  logic                                    rst_i,

   // Ethernet DMA master, highest priority
   input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]      dma_adr_i,
   input  logic [soc_bus_pkg::DATA_WIDTH-1:0]      dma_dat_i,
   input  logic [soc_bus_pkg::SEL_WIDTH-1:0]       dma_sel_i,
   input  logic                                    dma_we_i,
   input  logic                                    dma_cyc_i,
   input  logic                                    dma_stb_i,
   output logic [soc_bus_pkg::DATA_WIDTH-1:0]      dma_dat_o,
   output logic                                    dma_ack_o,
   output logic                                    dma_err_o,

   // CPU master
   input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]      cpu_adr_i,
   input  logic [soc_bus_pkg::DATA_WIDTH-1:0]      cpu_dat_i,
   input  logic [soc_bus_pkg::SEL_WIDTH-1:0]       cpu_sel_i,
   input  logic                                    cpu_we_i,
   input  logic                                    cpu_cyc_i,
   input  logic                                    cpu_stb_i,
   output logic [soc_bus_pkg::DATA_WIDTH-1:0]      cpu_dat_o,
   output logic                                    cpu_ack_o,
   output logic                                    cpu_err_o,

   // Ethernet slave
   output logic [soc_bus_pkg::ADDR_WIDTH-1:0]      eth_adr_o,
   output logic [soc_bus_pkg::DATA_WIDTH-1:0]      eth_dat_o,
   output logic [soc_bus_pkg::SEL_WIDTH-1:0]       eth_sel_o,
   output logic                                    eth_we_o,
   output logic                                    eth_cyc_o,
   output logic                                    eth_stb_o,
   input  logic [soc_bus_pkg::DATA_WIDTH-1:0]      eth_dat_i,
   input  logic                                    eth_ack_i,
   input  logic                                    eth_err_i,

   // UART slave
   output logic [soc_bus_pkg::UART_ADDR_WIDTH-1:0] uart_adr_o,
   output logic [soc_bus_pkg::DATA_WIDTH-1:0]      uart_dat_o,
   output logic [soc_bus_pkg::SEL_WIDTH-1:0]       uart_sel_o,
   output logic                                    uart_we_o,
   output logic                                    uart_cyc_o,
   output logic                                    uart_stb_o,
   input  logic [soc_bus_pkg::DATA_WIDTH-1:0]      uart_dat_i,
   input  logic                                    uart_ack_i,
   input  logic                                    uart_err_i
);
   import soc_bus_pkg::*;

   wb_if m_dma ();
   wb_if m_cpu ();
   wb_if s_sram ();
   wb_if s_eth ();
   wb_if s_uart ();

   logic [1:0]             grant;
   logic [SLAVE_COUNT-1:0] dma_sel;
   logic [SLAVE_COUNT-1:0] cpu_sel;

   assign m_dma.adr   = dma_adr_i;
   assign m_dma.dat_w = dma_dat_i;
   assign m_dma.sel   = dma_sel_i;
   assign m_dma.we    = dma_we_i;
   assign m_dma.cyc   = dma_cyc_i;
   assign m_dma.stb   = dma_stb_i;
   assign dma_dat_o   = m_dma.dat_r;
   assign dma_ack_o   = m_dma.ack;
   assign dma_err_o   = m_dma.err;

   assign m_cpu.adr   = cpu_adr_i;
   assign m_cpu.dat_w = cpu_dat_i;
   assign m_cpu.sel   = cpu_sel_i;
   assign m_cpu.we    = cpu_we_i;
   assign m_cpu.cyc   = cpu_cyc_i;
   assign m_cpu.stb   = cpu_stb_i;
   assign cpu_dat_o   = m_cpu.dat_r;
   assign cpu_ack_o   = m_cpu.ack;
   assign cpu_err_o   = m_cpu.err;

   assign eth_adr_o    = s_eth.adr;
   assign eth_dat_o    = s_eth.dat_w;
   assign eth_sel_o    = s_eth.sel;
   assign eth_we_o     = s_eth.we;
   assign eth_cyc_o    = s_eth.cyc;
   assign eth_stb_o    = s_eth.stb;
   assign s_eth.dat_r  = eth_dat_i;
   assign s_eth.ack    = eth_ack_i;
   assign s_eth.err    = eth_err_i;

   // Top byte is always the UART prefix
   assign uart_adr_o   = s_uart.adr[UART_ADDR_WIDTH-1:0];
   assign uart_dat_o   = s_uart.dat_w;
   assign uart_sel_o   = s_uart.sel;
   assign uart_we_o    = s_uart.we;
   assign uart_cyc_o   = s_uart.cyc;
   assign uart_stb_o   = s_uart.stb;
   assign s_uart.dat_r = uart_dat_i;
   assign s_uart.ack   = uart_ack_i;
   assign s_uart.err   = uart_err_i;

   wb_master_arbiter arbiter_i (
      .wb_clk_i (wb_clk_i),
      .rst_i    (rst_i),
      .dma      (m_dma),
      .cpu      (m_cpu),
      .grant_o  (grant)
   );

   wb_addr_decoder #(
      .SRAM_ADR_WIDTH (SRAM_ADR_WIDTH)
   ) decoder_i (
      .dma_adr_i (m_dma.adr),
      .cpu_adr_i (m_cpu.adr),
      .dma_sel_o (dma_sel),
      .cpu_sel_o (cpu_sel)
   );

   wb_bus_router router_i (
      .wb_clk_i  (wb_clk_i),
      .rst_i     (rst_i),
      .grant_i   (grant),
      .dma_sel_i (dma_sel),
      .cpu_sel_i (cpu_sel),
      .dma       (m_dma),
      .cpu       (m_cpu),
      .sram      (s_sram),
      .eth       (s_eth),
      .uart      (s_uart)
   );

   soc_sram #(
      .SRAM_ADR_WIDTH (SRAM_ADR_WIDTH)
   ) sram_i (
      .wb_clk_i (wb_clk_i),
      .rst_i    (rst_i),
      .bus      (s_sram)
   );

endmodule

//--- hw/soc_sram.sv
// On-chip SRAM as a Wishbone slave
// Byte-lane writes, registered single-cycle ack
`timescale 1ns/1ns

module soc_sram #(
   parameter int SRAM_ADR_WIDTH = 8
) (
   input  logic wb_clk_i,
   input  logic rst_i,
   wb_if.slave  bus
);
   import soc_bus_pkg::*;

   localparam int SRAM_WORDS = 2 ** SRAM_ADR_WIDTH;

   logic [DATA_WIDTH-1:0]     mem [SRAM_WORDS];
   logic [DATA_WIDTH-1:0]     rd_data;
   logic                      ack_q;
   logic                      access;
   logic [SRAM_ADR_WIDTH-1:0] word_idx;
   wb_addr_u                  addr;

   assign addr     = bus.adr;
   assign word_idx = addr.mem.word[SRAM_ADR_WIDTH-1:0];

   // Ack low here keeps a held request from being served twice
   assign access = bus.cyc && bus.stb && !ack_q;

   always_ff @(posedge wb_clk_i)
   begin
      if (rst_i)
      begin
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= access;
      end
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (access && bus.we)
      begin
         for (int i = 0; i < SEL_WIDTH; i++)
         begin
            if (bus.sel[i])
            begin
               mem[word_idx][i*8 +: 8] <= bus.dat_w[i*8 +: 8];
            end
         end
      end
      if (access)
      begin
         rd_data <= mem[word_idx];
      end
   end

   assign bus.dat_r = rd_data;
   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;

   a_ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      !(bus.cyc && bus.stb) |=> !bus.ack);

endmodule

//--- hw/wb_bus_router.sv
// Request mux from the granted master to the selected slave
// Response return path and error response for unmapped addresses
`timescale 1ns/1ns

module wb_bus_router (
   input  logic                                wb_clk_i,
   input  logic                                rst_i,
   input  logic [1:0]                          grant_i,
   input  logic [soc_bus_pkg::SLAVE_COUNT-1:0] dma_sel_i,
   input  logic [soc_bus_pkg::SLAVE_COUNT-1:0] cpu_sel_i,
   wb_if.slave                                 dma,
   wb_if.slave                                 cpu,
   wb_if.master                                sram,
   wb_if.master                                eth,
   wb_if.master                                uart
);
   import soc_bus_pkg::*;

   logic [ADDR_WIDTH-1:0]  req_adr;
   logic [DATA_WIDTH-1:0]  req_dat;
   logic [SEL_WIDTH-1:0]   req_sel;
   logic                   req_we;
   logic                   req_cyc;
   logic                   req_stb;
   logic [SLAVE_COUNT-1:0] slave_sel;
   logic [SLAVE_COUNT-1:0] slave_ack;
   logic [SLAVE_COUNT-1:0] slave_err;
   logic [DATA_WIDTH-1:0]  resp_dat;
   logic                   resp_ack;
   logic                   resp_err;
   logic                   unmapped;

   // Granted master's request, cyc and stb stay low when idle
   assign req_adr   = grant_i[1] ? cpu.adr   : dma.adr;
   assign req_dat   = grant_i[1] ? cpu.dat_w : dma.dat_w;
   assign req_sel   = grant_i[1] ? cpu.sel   : dma.sel;
   assign req_we    = grant_i[1] ? cpu.we    : dma.we;
   assign req_cyc   = (grant_i[0] && dma.cyc) || (grant_i[1] && cpu.cyc);
   assign req_stb   = (grant_i[0] && dma.stb) || (grant_i[1] && cpu.stb);
   assign slave_sel = grant_i[1] ? cpu_sel_i : dma_sel_i;

   assign sram.adr   = req_adr;
   assign sram.dat_w = req_dat;
   assign sram.sel   = req_sel;
   assign sram.we    = req_we;
   assign sram.cyc   = req_cyc && slave_sel[SLV_SRAM];
   assign sram.stb   = req_stb && slave_sel[SLV_SRAM];

   assign eth.adr    = req_adr;
   assign eth.dat_w  = req_dat;
   assign eth.sel    = req_sel;
   assign eth.we     = req_we;
   assign eth.cyc    = req_cyc && slave_sel[SLV_ETH];
   assign eth.stb    = req_stb && slave_sel[SLV_ETH];

   assign uart.adr   = req_adr;
   assign uart.dat_w = req_dat;
   assign uart.sel   = req_sel;
   assign uart.we    = req_we;
   assign uart.cyc   = req_cyc && slave_sel[SLV_UART];
   assign uart.stb   = req_stb && slave_sel[SLV_UART];

   // Response of the selected slave only
   always_comb
   begin
      slave_ack           = '0;
      slave_err           = '0;
      slave_ack[SLV_SRAM] = sram.ack;
      slave_ack[SLV_ETH]  = eth.ack;
      slave_ack[SLV_UART] = uart.ack;
      slave_err[SLV_SRAM] = sram.err;
      slave_err[SLV_ETH]  = eth.err;
      slave_err[SLV_UART] = uart.err;
   end

   always_comb
   begin
      resp_dat = '0;
      if (slave_sel[SLV_SRAM])
      begin
         resp_dat = sram.dat_r;
      end
      else if (slave_sel[SLV_ETH])
      begin
         resp_dat = eth.dat_r;
      end
      else if (slave_sel[SLV_UART])
      begin
         resp_dat = uart.dat_r;
      end
   end

   // No slave answers an unmapped address, so the router does
   assign unmapped = req_cyc && req_stb && (slave_sel == '0);
   assign resp_ack = req_cyc && |(slave_sel & slave_ack);
   assign resp_err = (req_cyc && |(slave_sel & slave_err)) || unmapped;

   assign dma.dat_r = grant_i[0] ? resp_dat : '0;
   assign dma.ack   = grant_i[0] && resp_ack;
   assign dma.err   = grant_i[0] && resp_err;
   assign cpu.dat_r = grant_i[1] ? resp_dat : '0;
   assign cpu.ack   = grant_i[1] && resp_ack;
   assign cpu.err   = grant_i[1] && resp_err;

   a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      !(dma.ack && dma.err) && !(cpu.ack && cpu.err));

   // A slave strobe always belongs to exactly one granted master
   a_stb_granted: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      (sram.stb || eth.stb || uart.stb) |-> $onehot(grant_i));

endmodule

//--- hw/wb_addr_decoder.sv
// Address decoder for both masters, one slave-select vector each
// All-zero select means the address is unmapped
`timescale 1ns/1ns

module wb_addr_decoder #(
   parameter int SRAM_ADR_WIDTH = 8
) (
   input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  dma_adr_i,
   input  logic [soc_bus_pkg::ADDR_WIDTH-1:0]  cpu_adr_i,
   output logic [soc_bus_pkg::SLAVE_COUNT-1:0] dma_sel_o,
   output logic [soc_bus_pkg::SLAVE_COUNT-1:0] cpu_sel_o
);
   import soc_bus_pkg::*;

   // Byte offset bits covered by the SRAM
   localparam int SRAM_OFS_BITS = SRAM_ADR_WIDTH + $clog2(SEL_WIDTH);

   function automatic logic [SLAVE_COUNT-1:0] decode_addr(input wb_addr_u addr);
      logic [SLAVE_COUNT-1:0] sel;
      logic                   sram_in_range;
      sel           = '0;
      // Offsets past the end of the SRAM are left unmapped
      sram_in_range = ((addr.map.offset >> SRAM_OFS_BITS) == '0);
      sel[SLV_SRAM] = (addr.map.prefix == PREFIX_SRAM) && sram_in_range;
      sel[SLV_ETH]  = (addr.map.prefix == PREFIX_ETH);
      sel[SLV_UART] = (addr.map.prefix == PREFIX_UART);
      return sel;
   endfunction

   wb_addr_u dma_addr;
   wb_addr_u cpu_addr;

   assign dma_addr = dma_adr_i;
   assign cpu_addr = cpu_adr_i;

   // Both masters decoded in parallel, the router picks by grant
   assign dma_sel_o = decode_addr(dma_addr);
   assign cpu_sel_o = decode_addr(cpu_addr);

endmodule

//--- hw/wb_master_arbiter.sv
// Fixed-priority bus grant between the DMA and CPU masters
// Grant is registered and held for the whole bus cycle of the owner
`timescale 1ns/1ns

module wb_master_arbiter (
   input  logic       wb_clk_i,
   input  logic       rst_i,
   wb_if.slave        dma,
   wb_if.slave        cpu,
   output logic [1:0] grant_o
);
   import soc_bus_pkg::*;

   // Bit 0 grants the DMA master, bit 1 the CPU master
   logic [1:0] grant_q;

   always_ff @(posedge wb_clk_i)
   begin
      if (rst_i)
      begin
         grant_q <= 2'b00;
      end
      else
      begin
         case (grant_q)
            2'b00:
            begin
               // DMA wins when both request together
               if (dma.cyc)
               begin
                  grant_q <= 2'b01;
               end
               else if (cpu.cyc)
               begin
                  grant_q <= 2'b10;
               end
            end
            2'b01:
            begin
               if (!dma.cyc)
               begin
                  grant_q <= 2'b00;
               end
            end
            2'b10:
            begin
               if (!cpu.cyc)
               begin
                  grant_q <= 2'b00;
               end
            end
            default:
            begin
               grant_q <= 2'b00;
            end
         endcase
      end
   end

   assign grant_o = grant_q;

   a_grant_onehot: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      $onehot0(grant_o));

endmodule

//--- hw/wb_if.sv
// Wishbone classic bus with master and slave modports
`timescale 1ns/1ns

interface wb_if;

   // Request, driven by the master
   logic [soc_bus_pkg::ADDR_WIDTH-1:0] adr;
   logic [soc_bus_pkg::DATA_WIDTH-1:0] dat_w;
   logic [soc_bus_pkg::SEL_WIDTH-1:0]  sel;
   logic                               we;
   logic                               cyc;
   logic                               stb;

   // Response, driven by the slave
   logic [soc_bus_pkg::DATA_WIDTH-1:0] dat_r;
   logic                               ack;
   logic                               err;

   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack, err
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack, err
   );

endinterface

//--- hw/soc_bus_pkg.sv
// Bus widths, address map prefixes and slave indices of the Wishbone switch
// Address word union with the map view and the memory view
package soc_bus_pkg;

   // Wishbone bus widths
   localparam int DATA_WIDTH   = 32;
   localparam int ADDR_WIDTH   = 32;
   localparam int SEL_WIDTH    = DATA_WIDTH / 8;
   localparam int PREFIX_WIDTH = 8;

   // Top address byte of each slave
   localparam logic [PREFIX_WIDTH-1:0] PREFIX_SRAM = 8'h00;
   localparam logic [PREFIX_WIDTH-1:0] PREFIX_ETH  = 8'h92;
   localparam logic [PREFIX_WIDTH-1:0] PREFIX_UART = 8'h90;

   // Bit positions in a slave-select vector
   localparam int SLAVE_COUNT = 3;
   localparam int SLV_SRAM    = 0;
   localparam int SLV_ETH     = 1;
   localparam int SLV_UART    = 2;

   // The UART only decodes the low address bits
   localparam int UART_ADDR_WIDTH = 24;

   // One address word seen two ways
   // map: slave prefix and offset inside that slave
   // mem: word index and byte offset inside the word
   typedef union packed {
      struct packed {
         logic [PREFIX_WIDTH-1:0]            prefix;
         logic [ADDR_WIDTH-PREFIX_WIDTH-1:0] offset;
      } map;
      struct packed {
         logic [ADDR_WIDTH-$clog2(SEL_WIDTH)-1:0] word;
         logic [$clog2(SEL_WIDTH)-1:0]            byte_ofs;
      } mem;
   } wb_addr_u;

endpackage
